// ==== common/arm_pkg.sv ====
`default_nettype none

package arm_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // N, Z, C, V from the top bit down.
    typedef logic [3:0]  flags_t;

    typedef logic [11:0] shift_op_t;
    typedef logic [23:0] imm24_t;

    // Execute commands; the zero code is the bubble left by reset or flush.
    typedef enum logic [3:0] {
        cmd_nop  = 4'b0000,
        cmd_mov  = 4'b0001,
        cmd_add  = 4'b0010,
        cmd_adc  = 4'b0011,
        cmd_sub  = 4'b0100,
        cmd_sbc  = 4'b0101,
        cmd_and  = 4'b0110,
        cmd_orr  = 4'b0111,
        cmd_eor  = 4'b1000,
        cmd_mvn  = 4'b1001,
        cmd_addr = 4'b1010
    } exe_cmd_t;

    typedef enum logic [3:0] {
        cond_eq = 4'h0,
        cond_ne = 4'h1,
        cond_cs = 4'h2,
        cond_cc = 4'h3,
        cond_mi = 4'h4,
        cond_pl = 4'h5,
        cond_vs = 4'h6,
        cond_vc = 4'h7,
        cond_hi = 4'h8,
        cond_ls = 4'h9,
        cond_ge = 4'ha,
        cond_lt = 4'hb,
        cond_gt = 4'hc,
        cond_le = 4'hd,
        cond_al = 4'he,
        cond_nv = 4'hf
    } cond_t;

endpackage

`default_nettype wire

// ==== decode/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  logic               instr_valid,
    input  arm_pkg::word_t     instr,
    input  arm_pkg::flags_t    flags,
    output logic               imm,
    output logic               mem_r_en,
    output logic               mem_w_en,
    output logic               wb_en,
    output logic               b,
    output logic               s,
    output arm_pkg::exe_cmd_t  exe_cmd,
    output arm_pkg::reg_idx_t  dest,
    output arm_pkg::reg_idx_t  src1,
    output arm_pkg::reg_idx_t  src2,
    output arm_pkg::shift_op_t shift_operand,
    output arm_pkg::imm24_t    signed_imm_24
);
    logic n, z, c, v;
    logic cond_pass, ok;
    logic is_dp, is_mem, is_br;
    logic dp_ok, writes;

    assign {n, z, c, v} = flags;

    always_comb begin
        case (arm_pkg::cond_t'(instr[31:28]))
            arm_pkg::cond_eq: cond_pass = z;
            arm_pkg::cond_ne: cond_pass = !z;
            arm_pkg::cond_cs: cond_pass = c;
            arm_pkg::cond_cc: cond_pass = !c;
            arm_pkg::cond_mi: cond_pass = n;
            arm_pkg::cond_pl: cond_pass = !n;
            arm_pkg::cond_vs: cond_pass = v;
            arm_pkg::cond_vc: cond_pass = !v;
            arm_pkg::cond_hi: cond_pass = c && !z;
            arm_pkg::cond_ls: cond_pass = !c || z;
            arm_pkg::cond_ge: cond_pass = (n == v);
            arm_pkg::cond_lt: cond_pass = (n != v);
            arm_pkg::cond_gt: cond_pass = !z && (n == v);
            arm_pkg::cond_le: cond_pass = z || (n != v);
            arm_pkg::cond_al: cond_pass = 1'b1;
            default:          cond_pass = 1'b0;
        endcase
    end

    // Only the pre-indexed, add, word form of LDR/STR with an immediate offset.
    assign is_dp  = (instr[27:26] == 2'b00);
    assign is_mem = (instr[27:26] == 2'b01) && (instr[25:21] == 5'b01100);
    assign is_br  = (instr[27:24] == 4'b1010);

    always_comb begin
        exe_cmd = arm_pkg::cmd_nop;
        dp_ok   = 1'b1;
        writes  = 1'b1;
        case (instr[24:21])
            4'b0000: exe_cmd = arm_pkg::cmd_and;
            4'b0001: exe_cmd = arm_pkg::cmd_eor;
            4'b0010: exe_cmd = arm_pkg::cmd_sub;
            4'b0100: exe_cmd = arm_pkg::cmd_add;
            4'b0101: exe_cmd = arm_pkg::cmd_adc;
            4'b0110: exe_cmd = arm_pkg::cmd_sbc;
            4'b1000: begin
                exe_cmd = arm_pkg::cmd_and;
                writes  = 1'b0;
            end
            4'b1010: begin
                exe_cmd = arm_pkg::cmd_sub;
                writes  = 1'b0;
            end
            4'b1100: exe_cmd = arm_pkg::cmd_orr;
            4'b1101: exe_cmd = arm_pkg::cmd_mov;
            4'b1111: exe_cmd = arm_pkg::cmd_mvn;
            default: dp_ok = 1'b0;
        endcase
        // TST and CMP without S encode other instructions.
        if (!writes && !instr[20]) begin
            dp_ok = 1'b0;
        end
        // Register-specified shifts and the multiply space are not handled.
        if (!instr[25] && instr[4]) begin
            dp_ok = 1'b0;
        end
        if (is_mem) begin
            exe_cmd = arm_pkg::cmd_addr;
        end
    end

    assign ok       = instr_valid && cond_pass;
    assign wb_en    = ok && is_dp && dp_ok && writes;
    assign s        = ok && is_dp && dp_ok && instr[20];
    assign mem_r_en = ok && is_mem && instr[20];
    assign mem_w_en = ok && is_mem && !instr[20];
    assign b        = ok && is_br;

    assign imm           = is_dp && instr[25];
    assign dest          = instr[15:12];
    assign src1          = instr[19:16];
    assign src2          = is_mem ? instr[15:12] : instr[3:0];
    assign shift_operand = instr[11:0];
    assign signed_imm_24 = instr[23:0];

endmodule

`default_nettype wire

// ==== decode/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
    parameter int num_regs = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  arm_pkg::reg_idx_t src1,
    input  arm_pkg::reg_idx_t src2,
    input  logic              we_en,
    input  arm_pkg::reg_idx_t we_dest,
    input  arm_pkg::word_t    we_value,
    output arm_pkg::word_t    val_rn,
    output arm_pkg::word_t    val_rm
);
    arm_pkg::word_t regs [num_regs];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we_en && int'(we_dest) < num_regs) begin
            regs[we_dest] <= we_value;
        end
    end

    // Reads are write-through so that decode sees the result still in execute.
    function automatic arm_pkg::word_t read_port(arm_pkg::reg_idx_t idx);
        if (we_en && idx == we_dest) begin
            return we_value;
        end
        if (int'(idx) >= num_regs) begin
            return '0;
        end
        return regs[idx];
    endfunction

    always_comb begin
        val_rn = read_port(src1);
        val_rm = read_port(src2);
    end

endmodule

`default_nettype wire

// ==== decode/id_stage_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

module id_stage_reg (
    input  logic               clk,
    input  logic               rst,
    input  logic               flush,
    input  logic               imm,
    input  logic               mem_r_en,
    input  logic               mem_w_en,
    input  logic               wb_en,
    input  logic               b,
    input  logic               s,
    input  arm_pkg::exe_cmd_t  exe_cmd,
    input  arm_pkg::reg_idx_t  dest,
    input  arm_pkg::reg_idx_t  src1,
    input  arm_pkg::reg_idx_t  src2,
    input  arm_pkg::shift_op_t shift_operand,
    input  arm_pkg::imm24_t    signed_imm_24,
    input  arm_pkg::flags_t    status_reg,
    input  arm_pkg::word_t     pc,
    input  arm_pkg::word_t     val_rn,
    input  arm_pkg::word_t     val_rm,
    output logic               ex_imm,
    output logic               ex_mem_r_en,
    output logic               ex_mem_w_en,
    output logic               ex_wb_en,
    output logic               ex_b,
    output logic               ex_s,
    output arm_pkg::exe_cmd_t  ex_exe_cmd,
    output arm_pkg::reg_idx_t  ex_dest,
    output arm_pkg::reg_idx_t  ex_src1,
    output arm_pkg::reg_idx_t  ex_src2,
    output arm_pkg::shift_op_t ex_shift_operand,
    output arm_pkg::imm24_t    ex_signed_imm_24,
    output arm_pkg::flags_t    ex_status_reg,
    output arm_pkg::word_t     ex_pc,
    output arm_pkg::word_t     ex_val_rn,
    output arm_pkg::word_t     ex_val_rm
);
    // A flushed slot becomes the all-zero bubble.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_imm           <= 1'b0;
            ex_mem_r_en      <= 1'b0;
            ex_mem_w_en      <= 1'b0;
            ex_wb_en         <= 1'b0;
            ex_b             <= 1'b0;
            ex_s             <= 1'b0;
            ex_exe_cmd       <= arm_pkg::cmd_nop;
            ex_dest          <= '0;
            ex_src1          <= '0;
            ex_src2          <= '0;
            ex_shift_operand <= '0;
            ex_signed_imm_24 <= '0;
            ex_status_reg    <= '0;
            ex_pc            <= '0;
            ex_val_rn        <= '0;
            ex_val_rm        <= '0;
        end else if (flush) begin
            ex_imm           <= 1'b0;
            ex_mem_r_en      <= 1'b0;
            ex_mem_w_en      <= 1'b0;
            ex_wb_en         <= 1'b0;
            ex_b             <= 1'b0;
            ex_s             <= 1'b0;
            ex_exe_cmd       <= arm_pkg::cmd_nop;
            ex_dest          <= '0;
            ex_src1          <= '0;
            ex_src2          <= '0;
            ex_shift_operand <= '0;
            ex_signed_imm_24 <= '0;
            ex_status_reg    <= '0;
            ex_pc            <= '0;
            ex_val_rn        <= '0;
            ex_val_rm        <= '0;
        end else begin
            ex_imm           <= imm;
            ex_mem_r_en      <= mem_r_en;
            ex_mem_w_en      <= mem_w_en;
            ex_wb_en         <= wb_en;
            ex_b             <= b;
            ex_s             <= s;
            ex_exe_cmd       <= exe_cmd;
            ex_dest          <= dest;
            ex_src1          <= src1;
            ex_src2          <= src2;
            ex_shift_operand <= shift_operand;
            ex_signed_imm_24 <= signed_imm_24;
            ex_status_reg    <= status_reg;
            ex_pc            <= pc;
            ex_val_rn        <= val_rn;
            ex_val_rm        <= val_rm;
        end
    end

endmodule

`default_nettype wire

// ==== execute/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  arm_pkg::exe_cmd_t  exe_cmd,
    input  logic               imm,
    input  arm_pkg::shift_op_t shift_operand,
    input  arm_pkg::word_t     val_rn,
    input  arm_pkg::word_t     val_rm,
    input  logic               carry_in,
    output arm_pkg::word_t     result,
    output arm_pkg::flags_t    nzcv,
    output logic               shifter_carry
);
    arm_pkg::word_t op2, op_b;
    logic [4:0]  amt;
    logic [63:0] rot;
    logic [32:0] sum;
    logic        cin, arith, v;

    // Immediates rotate right by twice the 4-bit field.
    assign amt = imm ? {shift_operand[11:8], 1'b0} : shift_operand[11:7];
    assign rot = imm ? {24'b0, shift_operand[7:0], 24'b0, shift_operand[7:0]} >> amt
                     : {val_rm, val_rm} >> amt;

    always_comb begin
        op2           = rot[31:0];
        shifter_carry = carry_in;
        if (exe_cmd == arm_pkg::cmd_addr) begin
            op2 = {20'b0, shift_operand};
        end else if (imm) begin
            if (amt != 5'd0) begin
                shifter_carry = rot[31];
            end
        end else if (amt == 5'd0) begin
            // Zero amount encodes LSR #32, ASR #32 and RRX.
            case (shift_operand[6:5])
                2'b01: begin
                    op2           = '0;
                    shifter_carry = val_rm[31];
                end
                2'b10: begin
                    op2           = {32{val_rm[31]}};
                    shifter_carry = val_rm[31];
                end
                2'b11: begin
                    op2           = {carry_in, val_rm[31:1]};
                    shifter_carry = val_rm[0];
                end
                default: ;
            endcase
        end else begin
            shifter_carry = val_rm[int'(amt) - 1];
            case (shift_operand[6:5])
                2'b00: begin
                    op2           = val_rm << amt;
                    shifter_carry = val_rm[32 - int'(amt)];
                end
                2'b01:   op2 = val_rm >> amt;
                2'b10:   op2 = $signed(val_rm) >>> amt;
                default: ;
            endcase
        end
    end

    always_comb begin
        arith = 1'b1;
        op_b  = op2;
        cin   = 1'b0;
        case (exe_cmd)
            arm_pkg::cmd_add, arm_pkg::cmd_addr: ;
            arm_pkg::cmd_adc: cin = carry_in;
            arm_pkg::cmd_sub: begin
                op_b = ~op2;
                cin  = 1'b1;
            end
            arm_pkg::cmd_sbc: begin
                op_b = ~op2;
                cin  = carry_in;
            end
            default: arith = 1'b0;
        endcase
        sum = {1'b0, val_rn} + {1'b0, op_b} + {32'b0, cin};
        case (exe_cmd)
            arm_pkg::cmd_mov: result = op2;
            arm_pkg::cmd_mvn: result = ~op2;
            arm_pkg::cmd_and: result = val_rn & op2;
            arm_pkg::cmd_orr: result = val_rn | op2;
            arm_pkg::cmd_eor: result = val_rn ^ op2;
            default:          result = sum[31:0];
        endcase
    end

    assign v    = arith && (val_rn[31] == op_b[31]) && (result[31] != val_rn[31]);
    assign nzcv = {result[31], result == '0, arith ? sum[32] : shifter_carry, v};

endmodule

`default_nettype wire

// ==== execute/exe_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exe_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               ex_imm,
    input  logic               ex_mem_r_en,
    input  logic               ex_mem_w_en,
    input  logic               ex_wb_en,
    input  logic               ex_b,
    input  logic               ex_s,
    input  arm_pkg::exe_cmd_t  ex_exe_cmd,
    input  arm_pkg::reg_idx_t  ex_dest,
    input  arm_pkg::shift_op_t ex_shift_operand,
    input  arm_pkg::imm24_t    ex_signed_imm_24,
    input  arm_pkg::flags_t    ex_status_reg,
    input  arm_pkg::word_t     ex_pc,
    input  arm_pkg::word_t     ex_val_rn,
    input  arm_pkg::word_t     ex_val_rm,
    output logic               we_en,
    output arm_pkg::reg_idx_t  we_dest,
    output arm_pkg::word_t     we_value,
    output arm_pkg::flags_t    flags_next,
    output logic               flush,
    output logic               wb_valid,
    output arm_pkg::reg_idx_t  wb_dest,
    output arm_pkg::word_t     wb_value,
    output logic               mem_read,
    output logic               mem_write,
    output arm_pkg::word_t     mem_addr,
    output arm_pkg::word_t     mem_wdata,
    output logic               branch_taken,
    output arm_pkg::word_t     branch_target,
    output arm_pkg::flags_t    flags
);
    arm_pkg::word_t  alu_result, target;
    arm_pkg::flags_t alu_nzcv;
    logic            logic_op;

    alu i_alu (
        .exe_cmd(ex_exe_cmd), .imm(ex_imm), .shift_operand(ex_shift_operand),
        .val_rn(ex_val_rn), .val_rm(ex_val_rm), .carry_in(ex_status_reg[1]),
        .result(alu_result), .nzcv(alu_nzcv), .shifter_carry()
    );

    assign logic_op = ex_exe_cmd inside {arm_pkg::cmd_mov, arm_pkg::cmd_mvn, arm_pkg::cmd_and,
                                         arm_pkg::cmd_orr, arm_pkg::cmd_eor};

    // Logical operations leave V alone.
    assign flags_next = ex_s ? {alu_nzcv[3:1], logic_op ? ex_status_reg[0] : alu_nzcv[0]}
                             : flags;

    assign we_en    = ex_wb_en;
    assign we_dest  = ex_dest;
    assign we_value = alu_result;
    assign flush    = ex_b;
    assign target   = ex_pc + 32'd8 + {{6{ex_signed_imm_24[23]}}, ex_signed_imm_24, 2'b00};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags         <= '0;
            wb_valid      <= 1'b0;
            wb_dest       <= '0;
            wb_value      <= '0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_addr      <= '0;
            mem_wdata     <= '0;
            branch_taken  <= 1'b0;
            branch_target <= '0;
        end else begin
            flags         <= flags_next;
            wb_valid      <= ex_wb_en;
            wb_dest       <= ex_dest;
            wb_value      <= alu_result;
            mem_read      <= ex_mem_r_en;
            mem_write     <= ex_mem_w_en;
            mem_addr      <= alu_result;
            mem_wdata     <= ex_val_rm;
            branch_taken  <= ex_b;
            branch_target <= target;
        end
    end

endmodule

`default_nettype wire

// ==== logic/arm_slice_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module arm_slice_top #(
    parameter int num_regs = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  arm_pkg::word_t    instr,
    input  arm_pkg::word_t    pc,
    output logic              wb_valid,
    output arm_pkg::reg_idx_t wb_dest,
    output arm_pkg::word_t    wb_value,
    output logic              mem_read,
    output logic              mem_write,
    output arm_pkg::word_t    mem_addr,
    output arm_pkg::word_t    mem_wdata,
    output logic              branch_taken,
    output arm_pkg::word_t    branch_target,
    output arm_pkg::flags_t   flags
);
    // Decode side.
    logic               imm, mem_r_en, mem_w_en, wb_en, b, s;
    arm_pkg::exe_cmd_t  exe_cmd;
    arm_pkg::reg_idx_t  dest, src1, src2;
    arm_pkg::shift_op_t shift_operand;
    arm_pkg::imm24_t    signed_imm_24;
    arm_pkg::word_t     val_rn, val_rm;

    // Execute side.
    logic               ex_imm, ex_mem_r_en, ex_mem_w_en, ex_wb_en, ex_b, ex_s;
    arm_pkg::exe_cmd_t  ex_exe_cmd;
    arm_pkg::reg_idx_t  ex_dest;
    arm_pkg::shift_op_t ex_shift_operand;
    arm_pkg::imm24_t    ex_signed_imm_24;
    arm_pkg::flags_t    ex_status_reg;
    arm_pkg::word_t     ex_pc, ex_val_rn, ex_val_rm;

    logic               we_en, flush;
    arm_pkg::reg_idx_t  we_dest;
    arm_pkg::word_t     we_value;
    arm_pkg::flags_t    flags_next;

    instr_decoder i_decoder (
        .instr_valid, .instr, .flags(flags_next),
        .imm, .mem_r_en, .mem_w_en, .wb_en, .b, .s,
        .exe_cmd, .dest, .src1, .src2, .shift_operand, .signed_imm_24
    );

    reg_file #(
        .num_regs(num_regs)
    ) i_reg_file (
        .clk, .rst, .src1, .src2,
        .we_en, .we_dest, .we_value,
        .val_rn, .val_rm
    );

    id_stage_reg i_id_stage_reg (
        .clk, .rst, .flush,
        .imm, .mem_r_en, .mem_w_en, .wb_en, .b, .s,
        .exe_cmd, .dest, .src1, .src2, .shift_operand, .signed_imm_24,
        .status_reg(flags_next), .pc, .val_rn, .val_rm,
        .ex_imm, .ex_mem_r_en, .ex_mem_w_en, .ex_wb_en, .ex_b, .ex_s,
        .ex_exe_cmd, .ex_dest, .ex_src1(), .ex_src2(),
        .ex_shift_operand, .ex_signed_imm_24,
        .ex_status_reg, .ex_pc, .ex_val_rn, .ex_val_rm
    );

    exe_stage i_exe_stage (
        .clk, .rst,
        .ex_imm, .ex_mem_r_en, .ex_mem_w_en, .ex_wb_en, .ex_b, .ex_s,
        .ex_exe_cmd, .ex_dest, .ex_shift_operand, .ex_signed_imm_24,
        .ex_status_reg, .ex_pc, .ex_val_rn, .ex_val_rm,
        .we_en, .we_dest, .we_value, .flags_next, .flush,
        .wb_valid, .wb_dest, .wb_value,
        .mem_read, .mem_write, .mem_addr, .mem_wdata,
        .branch_taken, .branch_target, .flags
    );

endmodule

`default_nettype wire

// ==== verif/arm_slice_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module arm_slice_props (
    input logic            clk,
    input logic            rst,
    input logic            wb_valid,
    input logic            mem_read,
    input logic            mem_write,
    input logic            branch_taken,
    input arm_pkg::flags_t flags
);
    a_mem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write are high in the same cycle");

    // The slot behind a taken branch is flushed.
    a_branch_shadow: assert property (@(posedge clk) disable iff (rst)
        branch_taken |=> !(wb_valid || mem_read || mem_write || branch_taken))
        else $error("an output is active in the cycle after a taken branch");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !(wb_valid || mem_read || mem_write || branch_taken) && flags == 4'h0)
        else $error("an output is active while reset is held");

endmodule

bind arm_slice_top arm_slice_props i_props (
    .clk, .rst, .wb_valid, .mem_read, .mem_write, .branch_taken, .flags
);

`default_nettype wire

// ==== verif/tb_arm_slice.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_arm_slice;
    localparam int num_directed = 16;
    localparam int num_random = 2000;
    localparam int num_instr = num_directed + num_random;
    localparam int cycle_limit = num_instr + 50;
    localparam logic [43:0] dp_ops = {4'hf, 4'hd, 4'hc, 4'ha, 4'h8, 4'h6,
                                      4'h5, 4'h4, 4'h2, 4'h1, 4'h0};

    logic        clk, rst, instr_valid;
    logic [31:0] instr, pc;
    logic        wb_valid, mem_read, mem_write, branch_taken;
    logic [3:0]  wb_dest, flags;
    logic [31:0] wb_value, mem_addr, mem_wdata, branch_target;

    // Reference model state.
    logic [31:0] m_regs [16];
    logic [3:0]  m_flags;
    logic        kill_next;
    logic [31:0] lfsr;
    // Strobes, flags, dest, value and store data of each slot in flight.
    logic [75:0] exp_q [$];
    int          errors, checks, cycles;

    arm_slice_top #(
        .num_regs(16)
    ) i_dut (
        .clk, .rst, .instr_valid, .instr, .pc,
        .wb_valid, .wb_dest, .wb_value, .mem_read, .mem_write, .mem_addr, .mem_wdata,
        .branch_taken, .branch_target, .flags
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < count; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        end
        return r;
    endfunction

    // Half of the picks come from R0..R3 so that dependent pairs are common.
    function automatic logic [3:0] pick_reg();
        logic [31:0] r;
        r = random_bits(1);
        r = r[0] ? random_bits(2) : random_bits(4);
        return r[3:0];
    endfunction

    function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic logic cond_holds(input logic [3:0] cond);
        logic n, z, c, v, r;
        {n, z, c, v} = m_flags;
        case (cond[3:1])
            3'd0: r = z;
            3'd1: r = c;
            3'd2: r = n;
            3'd3: r = v;
            3'd4: r = c && !z;
            3'd5: r = (n == v);
            3'd6: r = !z && (n == v);
            default: r = 1'b1;
        endcase
        // Odd codes negate the even ones.
        return (cond != 4'hf) && (r ^ cond[0]);
    endfunction

    task automatic shifter(input logic imm, input logic [11:0] f,
                           output logic [31:0] b, output logic sc);
        logic [31:0] rm;
        int          n, m;
        sc = m_flags[1];
        rm = m_regs[f[3:0]];
        if (imm) begin
            n = 2 * int'(f[11:8]);
            b = ror32({24'h0, f[7:0]}, n);
            if (n != 0) begin
                sc = b[31];
            end
        end else begin
            n = int'(f[11:7]);
            // LSR #0 and ASR #0 shift by 32.
            m = (n == 0) ? 32 : n;
            case (f[6:5])
                2'b00: begin
                    b = rm << n;
                    if (n != 0) begin
                        sc = rm[32 - n];
                    end
                end
                2'b01: begin
                    b = rm >> m;
                    sc = rm[m - 1];
                end
                2'b10: begin
                    b = $signed(rm) >>> m;
                    sc = rm[m - 1];
                end
                default: begin
                    // ROR #0 is RRX.
                    b = (n == 0) ? {m_flags[1], rm[31:1]} : ror32(rm, n);
                    sc = (n == 0) ? rm[0] : b[31];
                end
            endcase
        end
    endtask

    task automatic model_step(input logic valid, input logic [31:0] w);
        logic [3:0]  kind, op, dst;
        logic [31:0] a, b, res, value, wdata;
        logic [32:0] wide;
        logic        sc, c_new, v_new, killed;
        kind = 4'b0000;
        dst = 4'h0;
        value = '0;
        wdata = '0;
        killed = kill_next;
        kill_next = 1'b0;
        if (valid && !killed && cond_holds(w[31:28])) begin
            if (w[27:26] == 2'b00) begin
                op = w[24:21];
                a = m_regs[w[19:16]];
                shifter(w[25], w[11:0], b, sc);
                c_new = sc;
                v_new = m_flags[0];
                case (op)
                    4'h4, 4'h5: begin
                        wide = {1'b0, a} + {1'b0, b} + {32'h0, op[0] & m_flags[1]};
                        res = wide[31:0];
                        c_new = wide[32];
                        v_new = (a[31] == b[31]) && (res[31] != a[31]);
                    end
                    4'h2, 4'h6, 4'ha: begin
                        wide = {1'b0, a} - {1'b0, b} - {32'h0, (op == 4'h6) & !m_flags[1]};
                        res = wide[31:0];
                        c_new = !wide[32];
                        v_new = (a[31] != b[31]) && (res[31] != a[31]);
                    end
                    4'h1: res = a ^ b;
                    4'hc: res = a | b;
                    4'hd: res = b;
                    4'hf: res = ~b;
                    default: res = a & b;
                endcase
                if (w[20]) begin
                    m_flags = {res[31], res == 32'h0, c_new, v_new};
                end
                // TST and CMP only set flags.
                if (op != 4'h8 && op != 4'ha) begin
                    kind = 4'b1000;
                    dst = w[15:12];
                    value = res;
                    m_regs[dst] = res;
                end
            end else if (w[27:26] == 2'b01) begin
                kind = w[20] ? 4'b0100 : 4'b0010;
                value = m_regs[w[19:16]] + {20'h0, w[11:0]};
                wdata = m_regs[w[15:12]];
            end else begin
                kind = 4'b0001;
                // Word offset, sign-extended and scaled to bytes.
                a = {{8{w[23]}}, w[23:0]};
                value = pc + 32'd8 + 32'd4 * a;
                kill_next = 1'b1;
            end
        end
        exp_q.push_back({kind, m_flags, dst, value, wdata});
    endtask

    task automatic make_random(output logic valid, output logic [31:0] w);
        logic [31:0] cls, r;
        logic [3:0]  cond, op, rn, rd, rm;
        logic        s;
        cls = random_bits(4);
        r = random_bits(2);
        cond = 4'he;
        if (r[1:0] == 2'b00) begin
            r = random_bits(4);
            cond = (r[3:0] == 4'hf) ? 4'he : r[3:0];
        end
        rn = pick_reg();
        rd = pick_reg();
        rm = pick_reg();
        valid = 1'b1;
        if (cls < 10) begin
            r = random_bits(4);
            op = dp_ops[4 * (int'(r[3:0]) % 11) +: 4];
            r = random_bits(1);
            s = r[0] || op == 4'h8 || op == 4'ha;
            r = random_bits(13);
            if (r[12]) begin
                w = {cond, 3'b001, op, s, rn, rd, r[11:0]};
            end else begin
                w = {cond, 3'b000, op, s, rn, rd, r[11:5], 1'b0, rm};
            end
        end else if (cls < 13) begin
            r = random_bits(13);
            w = {cond, 2'b01, 5'b01100, r[12], rn, rd, r[11:0]};
        end else if (cls < 15) begin
            r = random_bits(24);
            w = {cond, 4'b1010, r[23:0]};
        end else begin
            valid = 1'b0;
            w = random_bits(32);
        end
    endtask

    task automatic check_outputs();
        logic [75:0] e;
        e = exp_q.pop_front();
        check_value("wb_valid/mem_read/mem_write/branch_taken",
                    32'({wb_valid, mem_read, mem_write, branch_taken}), 32'(e[75:72]));
        check_value("flags", 32'(flags), 32'(e[71:68]));
        if (e[75]) begin
            check_value("wb_dest", 32'(wb_dest), 32'(e[67:64]));
            check_value("wb_value", wb_value, e[63:32]);
        end
        if (e[74] || e[73]) begin
            check_value("mem_addr", mem_addr, e[63:32]);
        end
        if (e[73]) begin
            check_value("mem_wdata", mem_wdata, e[31:0]);
        end
        if (e[72]) begin
            check_value("branch_target", branch_target, e[63:32]);
        end
    endtask

    initial begin
        logic        valid;
        logic [31:0] word;
        clk = 1'b0;
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = 32'h0000_1000;
        lfsr = 32'hc291;
        m_flags = '0;
        kill_next = 1'b0;
        errors = 0;
        checks = 0;
        cycles = 0;
        foreach (m_regs[i]) begin
            m_regs[i] = '0;
        end
        // Two idle slots are in flight when reset ends.
        exp_q.push_back('0);
        exp_q.push_back('0);
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < num_instr + 2; i++) begin
            @(posedge clk);
            #2;
            check_outputs();
            if (i < num_directed) begin
                // MOV Ri, Ri reads back each register after reset.
                valid = 1'b1;
                word = 32'he1a0_0000 | (i << 12) | i;
            end else if (i < num_instr) begin
                make_random(valid, word);
            end else begin
                valid = 1'b0;
                word = '0;
            end
            instr_valid = valid;
            instr = word;
            pc = pc + 32'd4;
            model_step(valid, word);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/arm_pkg.sv
decode/instr_decoder.sv
decode/reg_file.sv
decode/id_stage_reg.sv
execute/alu.sv
execute/exe_stage.sv
logic/arm_slice_top.sv
verif/arm_slice_props.sv
verif/tb_arm_slice.sv

// ==== Bender.yml ====
package:
  name: arm_slice

sources:
  - common/arm_pkg.sv
  - decode/instr_decoder.sv
  - decode/reg_file.sv
  - decode/id_stage_reg.sv
  - execute/alu.sv
  - execute/exe_stage.sv
  - logic/arm_slice_top.sv
  - target: test
    files:
      - verif/arm_slice_props.sv
      - verif/tb_arm_slice.sv
